// ==== hw/matchedFilter_params.svh ====
`ifndef MATCHEDFILTER_PARAMS_SVH
`define MATCHEDFILTER_PARAMS_SVH

// Width of an input sample and of each coefficient part.
`define MF_DATA_WIDTH 12
// Number of taps in the loadable complex FIR.
`define MF_TAPS 8
// Hilbert FIR length, centre tap and the right shift applied to its sum.
`define MF_HT_TAPS 7
`define MF_HT_CENTER 3
`define MF_HT_SHIFT 7
// Odd-symmetric Hilbert taps; every odd index is zero.
`define MF_HT_TAP0 (-21)
`define MF_HT_TAP1 0
`define MF_HT_TAP2 (-64)
`define MF_HT_TAP3 0
`define MF_HT_TAP4 64
`define MF_HT_TAP5 0
`define MF_HT_TAP6 21
// Widths of the Hilbert parts, the FIR accumulators and the result.
`define MF_HT_WIDTH 16
`define MF_ACC_WIDTH 32
`define MF_MAG_WIDTH 32

`endif

// ==== hw/matchedFilterPkg.sv ====
`include "matchedFilter_params.svh"

// Word types and enums shared by the filter stages and the testbench.
package matchedFilterPkg;

	// A signed input sample, also used for each coefficient part.
	typedef logic signed [`MF_DATA_WIDTH-1:0] sample_t;
	// One part of a Hilbert output sample.
	typedef logic signed [`MF_HT_WIDTH-1:0] htWord_t;
	// One part of a complex FIR output.
	typedef logic signed [`MF_ACC_WIDTH-1:0] accWord_t;
	// The unsigned magnitude returned on the result channel.
	typedef logic [`MF_MAG_WIDTH-1:0] magWord_t;

	// Command opcodes on the request channel.
	typedef enum logic [1:0] {
		mfOpLoadCoeff,
		mfOpSample,
		mfOpClear
	} mfOp_e;

	// Controller states.
	typedef enum logic [2:0] {
		ctrlIdle,
		ctrlStep,
		ctrlWaitMag,
		ctrlResultReq,
		ctrlResultRel,
		ctrlReqRel
	} ctrlState_e;

	// Magnitude unit states.
	typedef enum logic [1:0] {magIdle, magSquare, magRoot, magDone} magState_e;

endpackage

// ==== hw/tapBusIf.sv ====
// One complex step passed from one filter stage to the next.
// The part type sets the width of the real and imaginary words.
interface tapBusIf #(
	parameter type partT = logic
);

	// Single-cycle pulse that carries a new sample in re and im.
	logic step;
	// Single-cycle pulse that zeroes the delay line of the receiving stage.
	logic clear;
	// Real part of the sample.
	partT re;
	// Imaginary part of the sample.
	partT im;

	// The upstream stage drives everything.
	modport source(output step, output clear, output re, output im);

	// The downstream stage only reads.
	modport sink(input step, input clear, input re, input im);

endinterface

// ==== hw/hilbertTransform.sv ====
`include "matchedFilter_params.svh"

// Short fixed Hilbert FIR.
// The real output is the input delayed to the filter centre and the imaginary
// output is the shifted tap sum, so together they form an analytic sample.
module hilbertTransform (
	input logic clock,
	input logic arstN,
	tapBusIf.sink htIn,
	tapBusIf.source firIn
);

	// Past samples; entry 0 is one step old.
	matchedFilterPkg::sample_t history [`MF_HT_TAPS-1];
	// The full seven-deep window: the arriving sample, then the history.
	matchedFilterPkg::sample_t window [`MF_HT_TAPS];
	// Unshifted tap sum.
	int htSum;

	// The window is what the delay line holds once the new sample is in.
	always_comb begin
		window[0] = htIn.re;
		for (int k = 1; k < `MF_HT_TAPS; k++) begin
			window[k] = history[k-1];
		end
	end

	// Only the even taps are nonzero, so the odd ones are left out of the sum.
	always_comb begin
		htSum = `MF_HT_TAP0 * int'(window[0]) + `MF_HT_TAP2 * int'(window[2]) +
			`MF_HT_TAP4 * int'(window[4]) + `MF_HT_TAP6 * int'(window[6]);
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `MF_HT_TAPS - 1; k++) begin
				history[k] <= '0;
			end
			firIn.step <= 1'b0;
			firIn.clear <= 1'b0;
			firIn.re <= '0;
			firIn.im <= '0;
		end else begin
			// Control pulses reach the FIR one cycle later, lined up with the data.
			firIn.step <= htIn.step;
			firIn.clear <= htIn.clear;
			if (htIn.clear) begin
				for (int k = 0; k < `MF_HT_TAPS - 1; k++) begin
					history[k] <= '0;
				end
			end else if (htIn.step) begin
				// Shift by one; the oldest sample drops off the end.
				for (int k = 0; k < `MF_HT_TAPS - 1; k++) begin
					history[k] <= window[k];
				end
				// Sign-extend the centre sample to the Hilbert word width.
				firIn.re <= matchedFilterPkg::htWord_t'(window[`MF_HT_CENTER]);
				// Arithmetic shift scales the taps back down.
				firIn.im <= matchedFilterPkg::htWord_t'(htSum >>> `MF_HT_SHIFT);
			end
		end
	end

endmodule

// ==== hw/complexFir.sv ====
`include "matchedFilter_params.svh"

// Complex FIR with coefficients loaded at run time.
// Each step shifts one analytic sample into the delay line and produces the
// complex multiply-accumulate over all taps one cycle later.
module complexFir (
	input logic clock,
	input logic arstN,
	input logic coeffLoad,
	input matchedFilterPkg::sample_t coeffRe,
	input matchedFilterPkg::sample_t coeffIm,
	tapBusIf.sink firIn,
	output logic firOutValid,
	output matchedFilterPkg::accWord_t firOutRe,
	output matchedFilterPkg::accWord_t firOutIm
);

	// Coefficient table.
	// Entry 0 multiplies the newest sample.
	matchedFilterPkg::sample_t coeffReTab [`MF_TAPS];
	matchedFilterPkg::sample_t coeffImTab [`MF_TAPS];
	// Stored samples; entry 0 is one step old.
	matchedFilterPkg::htWord_t historyRe [`MF_TAPS-1];
	matchedFilterPkg::htWord_t historyIm [`MF_TAPS-1];
	// Arriving sample followed by the stored history.
	matchedFilterPkg::htWord_t windowRe [`MF_TAPS];
	matchedFilterPkg::htWord_t windowIm [`MF_TAPS];
	// Combinational accumulator results.
	matchedFilterPkg::accWord_t macRe;
	matchedFilterPkg::accWord_t macIm;

	always_comb begin
		windowRe[0] = firIn.re;
		windowIm[0] = firIn.im;
		for (int k = 1; k < `MF_TAPS; k++) begin
			windowRe[k] = historyRe[k-1];
			windowIm[k] = historyIm[k-1];
		end
	end

	// (a + jb)(c + jd) = (ac - bd) + j(ad + bc), summed over the taps.
	// Operands are widened first so every product is formed at full width.
	always_comb begin
		macRe = '0;
		macIm = '0;
		for (int k = 0; k < `MF_TAPS; k++) begin
			macRe = macRe +
				matchedFilterPkg::accWord_t'(coeffReTab[k]) * matchedFilterPkg::accWord_t'(windowRe[k]) -
				matchedFilterPkg::accWord_t'(coeffImTab[k]) * matchedFilterPkg::accWord_t'(windowIm[k]);
			macIm = macIm +
				matchedFilterPkg::accWord_t'(coeffReTab[k]) * matchedFilterPkg::accWord_t'(windowIm[k]) +
				matchedFilterPkg::accWord_t'(coeffImTab[k]) * matchedFilterPkg::accWord_t'(windowRe[k]);
		end
	end

	// A load pushes the table toward entry 0 and the new word enters at the top.
	// After a full set of loads the first word loaded sits at entry 0.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `MF_TAPS; k++) begin
				coeffReTab[k] <= '0;
				coeffImTab[k] <= '0;
			end
		end else if (coeffLoad) begin
			for (int k = 0; k < `MF_TAPS - 1; k++) begin
				coeffReTab[k] <= coeffReTab[k+1];
				coeffImTab[k] <= coeffImTab[k+1];
			end
			coeffReTab[`MF_TAPS-1] <= coeffRe;
			coeffImTab[`MF_TAPS-1] <= coeffIm;
		end
	end

	// Data path; a clear empties the delay line and leaves the table alone.
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int k = 0; k < `MF_TAPS - 1; k++) begin
				historyRe[k] <= '0;
				historyIm[k] <= '0;
			end
			firOutValid <= 1'b0;
			firOutRe <= '0;
			firOutIm <= '0;
		end else begin
			firOutValid <= firIn.step;
			if (firIn.clear) begin
				for (int k = 0; k < `MF_TAPS - 1; k++) begin
					historyRe[k] <= '0;
					historyIm[k] <= '0;
				end
			end else if (firIn.step) begin
				for (int k = 0; k < `MF_TAPS - 1; k++) begin
					historyRe[k] <= windowRe[k];
					historyIm[k] <= windowIm[k];
				end
				firOutRe <= macRe;
				firOutIm <= macIm;
			end
		end
	end

endmodule

// ==== hw/magnitudeUnit.sv ====
`include "matchedFilter_params.svh"

// Magnitude of the complex FIR output.
// One cycle forms re^2 + im^2, then a restoring square root produces one
// result bit per cycle, most significant bit first.
module magnitudeUnit (
	input logic clock,
	input logic arstN,
	input logic firOutValid,
	input matchedFilterPkg::accWord_t firOutRe,
	input matchedFilterPkg::accWord_t firOutIm,
	output logic magDone,
	output matchedFilterPkg::magWord_t magValue
);

	localparam int RootBits = `MF_MAG_WIDTH;

	matchedFilterPkg::magState_e state;
	// Operands captured when the FIR output is valid.
	matchedFilterPkg::accWord_t opRe;
	matchedFilterPkg::accWord_t opIm;
	// Sum of squares; two bits are consumed from the top each root cycle.
	logic [2*RootBits-1:0] radicand;
	// Partial remainder, never more than twice the partial root.
	logic [RootBits+1:0] remainder;
	matchedFilterPkg::magWord_t root;
	logic [$clog2(RootBits)-1:0] bitCount;
	// Remainder with the next radicand pair shifted in, and the trial subtrahend.
	logic [RootBits+3:0] remShift;
	logic [RootBits+3:0] trial;
	logic [RootBits+3:0] remNext;
	logic trialFits;

	always_comb begin
		remShift = {remainder, radicand[2*RootBits-1 -: 2]};
		trial = {2'b00, root, 2'b01};
		trialFits = remShift >= trial;
		remNext = trialFits ? remShift - trial : remShift;
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= matchedFilterPkg::magIdle;
			opRe <= '0;
			opIm <= '0;
			radicand <= '0;
			remainder <= '0;
			root <= '0;
			bitCount <= '0;
		end else begin
			case (state)
				matchedFilterPkg::magIdle: begin
					if (firOutValid) begin
						opRe <= firOutRe;
						opIm <= firOutIm;
						state <= matchedFilterPkg::magSquare;
					end
				end
				matchedFilterPkg::magSquare: begin
					// Both squares are non-negative, so the signed sum fits unsigned.
					radicand <= longint'(opRe) * longint'(opRe) + longint'(opIm) * longint'(opIm);
					remainder <= '0;
					root <= '0;
					bitCount <= '1;
					state <= matchedFilterPkg::magRoot;
				end
				matchedFilterPkg::magRoot: begin
					// Keep the subtraction only when the trial fits.
					remainder <= remNext[RootBits+1:0];
					root <= {root[RootBits-2:0], trialFits};
					radicand <= radicand << 2;
					bitCount <= bitCount - 1'b1;
					if (bitCount == '0) begin
						state <= matchedFilterPkg::magDone;
					end
				end
				default: begin
					state <= matchedFilterPkg::magIdle;
				end
			endcase
		end
	end

	// The root holds still in the done state, so it is the result directly.
	assign magDone = (state == matchedFilterPkg::magDone);
	assign magValue = root;

endmodule

// ==== hw/matchedFilterCtrl.sv ====
// Controller for the command and result channels.
// It decodes one command at a time, pulses the matching stage control, and
// holds inAck low for a sample until that sample's result has been taken.
module matchedFilterCtrl (
	input logic clock,
	input logic arstN,
	input logic inReq,
	input matchedFilterPkg::mfOp_e inOp,
	input matchedFilterPkg::sample_t inRe,
	input matchedFilterPkg::sample_t inIm,
	output logic inAck,
	output logic resultReq,
	input logic resultAck,
	output matchedFilterPkg::magWord_t resultData,
	input logic magDone,
	input matchedFilterPkg::magWord_t magValue,
	output logic coeffLoad,
	output matchedFilterPkg::sample_t coeffRe,
	output matchedFilterPkg::sample_t coeffIm,
	tapBusIf.source htIn
);

	matchedFilterPkg::ctrlState_e state;
	// Command captured when the request is seen.
	matchedFilterPkg::mfOp_e cmdOp;
	matchedFilterPkg::sample_t cmdRe;
	matchedFilterPkg::sample_t cmdIm;
	logic stepCycle;

	// Every stage pulse lasts exactly the one step cycle.
	assign stepCycle = (state == matchedFilterPkg::ctrlStep);
	assign htIn.step = stepCycle && (cmdOp == matchedFilterPkg::mfOpSample);
	assign htIn.clear = stepCycle && (cmdOp == matchedFilterPkg::mfOpClear);
	assign coeffLoad = stepCycle && (cmdOp == matchedFilterPkg::mfOpLoadCoeff);
	assign htIn.re = cmdRe;
	// The input is real, so the imaginary part into the Hilbert FIR is zero.
	assign htIn.im = '0;
	assign coeffRe = cmdRe;
	assign coeffIm = cmdIm;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			state <= matchedFilterPkg::ctrlIdle;
			cmdOp <= matchedFilterPkg::mfOpLoadCoeff;
			cmdRe <= '0;
			cmdIm <= '0;
			inAck <= 1'b0;
			resultReq <= 1'b0;
			resultData <= '0;
		end else begin
			case (state)
				matchedFilterPkg::ctrlIdle: begin
					if (inReq && !inAck) begin
						cmdOp <= inOp;
						cmdRe <= inRe;
						cmdIm <= inIm;
						// Loads and clears finish at once; a sample waits for its result.
						inAck <= (inOp != matchedFilterPkg::mfOpSample);
						state <= matchedFilterPkg::ctrlStep;
					end
				end
				matchedFilterPkg::ctrlStep: begin
					if (cmdOp == matchedFilterPkg::mfOpSample) begin
						state <= matchedFilterPkg::ctrlWaitMag;
					end else begin
						state <= matchedFilterPkg::ctrlReqRel;
					end
				end
				matchedFilterPkg::ctrlWaitMag: begin
					if (magDone) begin
						resultData <= magValue;
						resultReq <= 1'b1;
						state <= matchedFilterPkg::ctrlResultReq;
					end
				end
				matchedFilterPkg::ctrlResultReq: begin
					// resultData stays put until the receiver has acknowledged.
					if (resultAck) begin
						resultReq <= 1'b0;
						state <= matchedFilterPkg::ctrlResultRel;
					end
				end
				matchedFilterPkg::ctrlResultRel: begin
					// Result handshake complete, so release the sample command.
					if (!resultAck) begin
						inAck <= 1'b1;
						state <= matchedFilterPkg::ctrlReqRel;
					end
				end
				default: begin
					if (!inReq) begin
						inAck <= 1'b0;
						state <= matchedFilterPkg::ctrlIdle;
					end
				end
			endcase
		end
	end

endmodule

// ==== hw/matchedFilter.sv ====
// Streaming complex matched filter.
// A real sample goes through the Hilbert FIR, the loadable complex FIR and the
// magnitude unit; the controller serves the two four-phase channels.
module matchedFilter (
	input logic clock,
	input logic arstN,
	input logic inReq,
	input matchedFilterPkg::mfOp_e inOp,
	input matchedFilterPkg::sample_t inRe,
	input matchedFilterPkg::sample_t inIm,
	output logic inAck,
	output logic resultReq,
	input logic resultAck,
	output matchedFilterPkg::magWord_t resultData
);

	// Controller to Hilbert FIR, and Hilbert FIR to complex FIR.
	tapBusIf #(.partT(matchedFilterPkg::sample_t)) htIn ();
	tapBusIf #(.partT(matchedFilterPkg::htWord_t)) firIn ();

	// Coefficient load from the controller.
	logic coeffLoad;
	matchedFilterPkg::sample_t coeffRe;
	matchedFilterPkg::sample_t coeffIm;
	// Complex FIR output into the magnitude unit.
	logic firOutValid;
	matchedFilterPkg::accWord_t firOutRe;
	matchedFilterPkg::accWord_t firOutIm;
	// Finished magnitude back to the controller.
	logic magDone;
	matchedFilterPkg::magWord_t magValue;

	matchedFilterCtrl ctrl (
		.clock(clock), .arstN(arstN),
		.inReq(inReq), .inOp(inOp), .inRe(inRe), .inIm(inIm), .inAck(inAck),
		.resultReq(resultReq), .resultAck(resultAck), .resultData(resultData),
		.magDone(magDone), .magValue(magValue),
		.coeffLoad(coeffLoad), .coeffRe(coeffRe), .coeffIm(coeffIm),
		.htIn(htIn.source)
	);

	hilbertTransform hilbert (
		.clock(clock), .arstN(arstN),
		.htIn(htIn.sink), .firIn(firIn.source)
	);

	complexFir fir (
		.clock(clock), .arstN(arstN),
		.coeffLoad(coeffLoad), .coeffRe(coeffRe), .coeffIm(coeffIm),
		.firIn(firIn.sink),
		.firOutValid(firOutValid), .firOutRe(firOutRe), .firOutIm(firOutIm)
	);

	magnitudeUnit mag (
		.clock(clock), .arstN(arstN),
		.firOutValid(firOutValid), .firOutRe(firOutRe), .firOutIm(firOutIm),
		.magDone(magDone), .magValue(magValue)
	);

endmodule

// ==== sim/clockGen.sv ====
// Free-running testbench clock and an active-low reset held for a set number of cycles.
module clockGen #(
	parameter int Period = 40,
	parameter int ResetCycles = 10,
	parameter int ReleaseDelay = 2
) (
	output logic clock,
	output logic arstN
);

	initial begin
		clock = 1'b0;
		forever begin
			#(Period / 2) clock = ~clock;
		end
	end

	// Release lands just after an edge, away from where the DUT samples.
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clock);
		#ReleaseDelay arstN = 1'b1;
	end

endmodule

// ==== sim/matchedFilterTb.sv ====
`include "matchedFilter_params.svh"

// Directed testbench for the streaming complex matched filter.
// A reference model keeps the coefficient table and both delay lines.
module matchedFilterTb;

	localparam int DriveDelay = 2;
	localparam int Timeout = 200;
	localparam int Seed = 53579;
	localparam int HtTaps [`MF_HT_TAPS] = '{`MF_HT_TAP0, `MF_HT_TAP1, `MF_HT_TAP2,
		`MF_HT_TAP3, `MF_HT_TAP4, `MF_HT_TAP5, `MF_HT_TAP6};

	logic clock;
	logic arstN;
	logic inReq;
	matchedFilterPkg::mfOp_e inOp;
	matchedFilterPkg::sample_t inRe;
	matchedFilterPkg::sample_t inIm;
	logic inAck;
	logic resultReq;
	logic resultAck;
	matchedFilterPkg::magWord_t resultData;

	// Model state; index 0 of each delay line holds the newest sample.
	matchedFilterPkg::sample_t htLine [`MF_HT_TAPS];
	matchedFilterPkg::htWord_t firLineRe [`MF_TAPS];
	matchedFilterPkg::htWord_t firLineIm [`MF_TAPS];
	matchedFilterPkg::sample_t tabRe [`MF_TAPS];
	matchedFilterPkg::sample_t tabIm [`MF_TAPS];

	clockGen #(.Period(40), .ResetCycles(10)) clkGen (.clock(clock), .arstN(arstN));

	matchedFilter uut (
		.clock(clock), .arstN(arstN),
		.inReq(inReq), .inOp(inOp), .inRe(inRe), .inIm(inIm), .inAck(inAck),
		.resultReq(resultReq), .resultAck(resultAck), .resultData(resultData)
	);

	// Inputs change and outputs are sampled a little after each rising edge.
	task automatic nextCycle();
		@(posedge clock);
		#DriveDelay;
	endtask

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic checkMag(input matchedFilterPkg::magWord_t expected,
			input matchedFilterPkg::magWord_t actual);
		if (actual !== expected) begin
			reportFailure($sformatf("mismatch resultData expected 0x%08h actual 0x%08h",
				expected, actual));
		end
	endtask

	task automatic checkBit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			reportFailure($sformatf("mismatch %s expected 0x%h actual 0x%h",
				name, expected, actual));
		end
	endtask

	// Sets each root bit from the top whenever its square still fits.
	function automatic matchedFilterPkg::magWord_t floorRoot(input logic [63:0] value);
		logic [31:0] root;
		logic [31:0] trialRoot;
		root = '0;
		for (int b = 31; b >= 0; b--) begin
			trialRoot = root | (32'd1 << b);
			if (64'(trialRoot) * 64'(trialRoot) <= value) begin
				root = trialRoot;
			end
		end
		return root;
	endfunction

	// The table moves toward index 0 and the new word enters at the top.
	function automatic void modelLoad(input matchedFilterPkg::sample_t re,
			input matchedFilterPkg::sample_t im);
		for (int k = 0; k < `MF_TAPS - 1; k++) begin
			tabRe[k] = tabRe[k+1];
			tabIm[k] = tabIm[k+1];
		end
		tabRe[`MF_TAPS-1] = re;
		tabIm[`MF_TAPS-1] = im;
	endfunction

	// A clear empties both delay lines but the coefficients survive.
	function automatic void modelClear();
		for (int k = 0; k < `MF_HT_TAPS; k++) begin
			htLine[k] = '0;
		end
		for (int k = 0; k < `MF_TAPS; k++) begin
			firLineRe[k] = '0;
			firLineIm[k] = '0;
		end
	endfunction

	// One sample through the Hilbert FIR, the complex FIR and the magnitude.
	function automatic matchedFilterPkg::magWord_t modelStep(input matchedFilterPkg::sample_t s);
		int tapSum;
		longint accRe;
		longint accIm;
		matchedFilterPkg::accWord_t outRe;
		matchedFilterPkg::accWord_t outIm;
		for (int k = `MF_HT_TAPS - 1; k > 0; k--) begin
			htLine[k] = htLine[k-1];
		end
		htLine[0] = s;
		tapSum = 0;
		for (int k = 0; k < `MF_HT_TAPS; k++) begin
			tapSum += HtTaps[k] * int'(htLine[k]);
		end
		for (int k = `MF_TAPS - 1; k > 0; k--) begin
			firLineRe[k] = firLineRe[k-1];
			firLineIm[k] = firLineIm[k-1];
		end
		firLineRe[0] = matchedFilterPkg::htWord_t'(htLine[`MF_HT_CENTER]);
		firLineIm[0] = matchedFilterPkg::htWord_t'(tapSum >>> `MF_HT_SHIFT);
		accRe = 0;
		accIm = 0;
		for (int k = 0; k < `MF_TAPS; k++) begin
			accRe += longint'(tabRe[k]) * longint'(firLineRe[k]) -
				longint'(tabIm[k]) * longint'(firLineIm[k]);
			accIm += longint'(tabRe[k]) * longint'(firLineIm[k]) +
				longint'(tabIm[k]) * longint'(firLineRe[k]);
		end
		outRe = matchedFilterPkg::accWord_t'(accRe);
		outIm = matchedFilterPkg::accWord_t'(accIm);
		return floorRoot(64'(longint'(outRe) * longint'(outRe) +
			longint'(outIm) * longint'(outIm)));
	endfunction

	// Takes one result; resultAck is held low for ackDelay cycles first.
	task automatic getResult(input matchedFilterPkg::magWord_t expected, input int ackDelay);
		int cycles;
		cycles = 0;
		while (resultReq !== 1'b1) begin
			if (cycles >= Timeout) begin
				reportFailure("result handshake stalled: resultReq never rose");
			end
			checkBit("inAck", 1'b0, inAck);
			nextCycle();
			cycles++;
		end
		checkMag(expected, resultData);
		repeat (ackDelay) begin
			nextCycle();
			checkBit("resultReq", 1'b1, resultReq);
			checkBit("inAck", 1'b0, inAck);
			checkMag(expected, resultData);
		end
		resultAck = 1'b1;
		cycles = 0;
		while (resultReq !== 1'b0) begin
			if (cycles >= Timeout) begin
				reportFailure("result handshake stalled: resultReq never fell");
			end
			checkMag(expected, resultData);
			checkBit("inAck", 1'b0, inAck);
			nextCycle();
			cycles++;
		end
		// The sample stays unacknowledged until resultAck has been lowered.
		checkBit("inAck", 1'b0, inAck);
		resultAck = 1'b0;
	endtask

	// Runs one four-phase command; a sample also serves its result handshake.
	task automatic sendCmd(input matchedFilterPkg::mfOp_e op, input matchedFilterPkg::sample_t re,
			input matchedFilterPkg::sample_t im, input matchedFilterPkg::magWord_t expected,
			input int ackDelay);
		int cycles;
		inOp = op;
		inRe = re;
		inIm = im;
		inReq = 1'b1;
		if (op == matchedFilterPkg::mfOpSample) begin
			getResult(expected, ackDelay);
		end
		cycles = 0;
		while (inAck !== 1'b1) begin
			if (cycles >= Timeout) begin
				reportFailure("command handshake stalled: inAck never rose");
			end
			nextCycle();
			cycles++;
		end
		inReq = 1'b0;
		cycles = 0;
		while (inAck !== 1'b0) begin
			if (cycles >= Timeout) begin
				reportFailure("command handshake stalled: inAck never fell");
			end
			nextCycle();
			cycles++;
		end
	endtask

	task automatic loadCoeff(input matchedFilterPkg::sample_t re,
			input matchedFilterPkg::sample_t im);
		modelLoad(re, im);
		sendCmd(matchedFilterPkg::mfOpLoadCoeff, re, im, '0, 0);
	endtask

	task automatic clearLines();
		modelClear();
		sendCmd(matchedFilterPkg::mfOpClear, '0, '0, '0, 0);
	endtask

	task automatic pushSample(input matchedFilterPkg::sample_t s, input int ackDelay);
		matchedFilterPkg::magWord_t expected;
		expected = modelStep(s);
		sendCmd(matchedFilterPkg::mfOpSample, s, '0, expected, ackDelay);
	endtask

	task automatic loadRandomTable();
		for (int k = 0; k < `MF_TAPS; k++) begin
			loadCoeff(matchedFilterPkg::sample_t'($urandom), matchedFilterPkg::sample_t'($urandom));
		end
	endtask

	task automatic pushRandom(input int count, input int maxDelay);
		for (int n = 0; n < count; n++) begin
			pushSample(matchedFilterPkg::sample_t'($urandom), int'($urandom_range(maxDelay, 0)));
		end
	endtask

	task automatic testReset();
		int cycles;
		cycles = 0;
		while (arstN !== 1'b1) begin
			if (cycles >= Timeout) begin
				reportFailure("reset was never released");
			end
			nextCycle();
			cycles++;
		end
		nextCycle();
		checkBit("inAck", 1'b0, inAck);
		checkBit("resultReq", 1'b0, resultReq);
		checkMag('0, resultData);
	endtask

	// A delta at tap 0 turns each result into the Hilbert output magnitude.
	task automatic testImpulse();
		loadCoeff(12'sd1, 12'sd0);
		for (int k = 1; k < `MF_TAPS; k++) begin
			loadCoeff(12'sd0, 12'sd0);
		end
		clearLines();
		pushSample(12'sd1024, 0);
		for (int n = 0; n < 14; n++) begin
			pushSample(12'sd0, 0);
		end
	endtask

	task automatic testRandomStream();
		loadRandomTable();
		pushRandom(40, 2);
	endtask

	task automatic testClear();
		pushRandom(10, 2);
		clearLines();
		pushRandom(15, 2);
	endtask

	task automatic testBackPressure();
		for (int n = 0; n < 10; n++) begin
			pushSample(matchedFilterPkg::sample_t'($urandom), int'($urandom_range(15, 1)));
		end
	endtask

	// New coefficients mid-stream; the data history must carry over.
	task automatic testReload();
		pushRandom(10, 1);
		loadRandomTable();
		pushRandom(12, 1);
	endtask

	initial begin
		inReq = 1'b0;
		inOp = matchedFilterPkg::mfOpLoadCoeff;
		inRe = '0;
		inIm = '0;
		resultAck = 1'b0;
		modelClear();
		for (int k = 0; k < `MF_TAPS; k++) begin
			tabRe[k] = '0;
			tabIm[k] = '0;
		end
		void'($urandom(Seed));
		testReset();
		testImpulse();
		testRandomStream();
		testClear();
		testBackPressure();
		testReload();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== matchedFilter.f ====
+incdir+hw
hw/matchedFilterPkg.sv
hw/tapBusIf.sv
hw/hilbertTransform.sv
hw/complexFir.sv
hw/magnitudeUnit.sv
hw/matchedFilterCtrl.sv
hw/matchedFilter.sv
sim/clockGen.sv
sim/matchedFilterTb.sv

// ==== Makefile ====
# Verilator build and run for the matched filter testbench.
VERILATOR ?= verilator
TOP ?= matchedFilterTb
FILELIST ?= matchedFilter.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary -j 0
PASS_MSG ?= ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The run passes only if the simulation output holds the pass message.
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
